//--- hdl/decoder_pkg.sv
package decoder_pkg;

    // grid geometry
    localparam int CODE_DISTANCE_X = 3;
    localparam int CODE_DISTANCE_Z = 3;
    localparam int MEASUREMENT_ROUNDS =
        (CODE_DISTANCE_X > CODE_DISTANCE_Z) ? CODE_DISTANCE_X : CODE_DISTANCE_Z;
    localparam int LAYER_SIZE = CODE_DISTANCE_X * CODE_DISTANCE_Z;
    localparam int PU_COUNT = LAYER_SIZE * MEASUREMENT_ROUNDS;
    localparam int ADDRESS_WIDTH = $clog2(PU_COUNT);

    // edge weights and grow steps per link
    localparam int WEIGHT_X = 1;
    localparam int WEIGHT_Z = 1;
    localparam int WEIGHT_UD = 1;
    localparam int NEIGHBOR_COST_X = 2 * WEIGHT_X;
    localparam int NEIGHBOR_COST_Z = 2 * WEIGHT_Z;
    localparam int NEIGHBOR_COST_UD = 2 * WEIGHT_UD;
    localparam int MAX_COST_XZ =
        (NEIGHBOR_COST_X > NEIGHBOR_COST_Z) ? NEIGHBOR_COST_X : NEIGHBOR_COST_Z;
    localparam int MAX_NEIGHBOR_COST =
        (MAX_COST_XZ > NEIGHBOR_COST_UD) ? MAX_COST_XZ : NEIGHBOR_COST_UD;
    localparam int GROWTH_WIDTH = $clog2(MAX_NEIGHBOR_COST + 1);

    // each unit owns the three link slots toward its higher neighbors
    localparam int DIR_X = 0;
    localparam int DIR_Z = 1;
    localparam int DIR_UD = 2;
    localparam int DIR_COUNT = 3;
    localparam int LINK_SLOTS = PU_COUNT * DIR_COUNT;

    typedef logic [ADDRESS_WIDTH-1:0] address_t;

    typedef enum logic [1:0] {
        STAGE_IDLE,
        STAGE_LOAD,
        STAGE_GROW,
        STAGE_MERGE
    } stage_t;

    function automatic int pu_index(int i, int j, int k);
        return i * CODE_DISTANCE_Z + j + k * LAYER_SIZE;
    endfunction

    function automatic int dir_stride(int dir);
        return (dir == DIR_X) ? CODE_DISTANCE_Z : ((dir == DIR_Z) ? 1 : LAYER_SIZE);
    endfunction

    function automatic int dir_size(int dir);
        return (dir == DIR_X) ? CODE_DISTANCE_X :
               ((dir == DIR_Z) ? CODE_DISTANCE_Z : MEASUREMENT_ROUNDS);
    endfunction

    // side 0..2 looks toward lower index, 3..5 toward higher index
    function automatic logic has_neighbor(int index, int side);
        int dir;
        int coord;
        dir = side % DIR_COUNT;
        coord = (index / dir_stride(dir)) % dir_size(dir);
        if (side < DIR_COUNT) begin
            return coord > 0;
        end
        return coord < dir_size(dir) - 1;
    endfunction

    // compact position of a side among the sides that exist
    function automatic int neighbor_pos(int index, int side);
        int pos;
        pos = 0;
        for (int s = 0; s < side; s++) begin
            pos += int'(has_neighbor(index, s));
        end
        return pos;
    endfunction

    function automatic int neighbor_count(int index);
        return neighbor_pos(index, 2 * DIR_COUNT);
    endfunction

    function automatic int link_slot(int index, int side);
        int dir;
        int owner;
        dir = side % DIR_COUNT;
        owner = (side < DIR_COUNT) ? index - dir_stride(dir) : index;
        return owner * DIR_COUNT + dir;
    endfunction

endpackage

//--- hdl/link_if.sv
interface link_if;
    import decoder_pkg::*;

    // unit A is the lower-index end of the edge
    address_t a_root;
    logic     a_occupied;
    address_t b_root;
    logic     b_occupied;
    logic     fully_grown;

    modport side_a (
        output a_root,
        output a_occupied,
        input  b_root,
        input  b_occupied,
        input  fully_grown
    );

    modport side_b (
        output b_root,
        output b_occupied,
        input  a_root,
        input  a_occupied,
        input  fully_grown
    );

    modport link (
        input  a_occupied,
        input  b_occupied,
        output fully_grown
    );

endinterface

//--- hdl/stage_control.sv
module stage_control (
    input  logic                               clk,
    input  logic                               reset,
    input  decoder_pkg::stage_t                stage_i,
    input  logic                               stage_valid_i,
    input  logic [decoder_pkg::PU_COUNT-1:0]   changed_i,
    output logic                               load_o,
    output logic                               grow_o,
    output logic                               merge_active_o,
    output logic                               busy_o
);
    import decoder_pkg::*;

    logic   strobe_q;
    stage_t stage_q;
    logic   merge_q;

    // stage code sampled beside the strobe
    always_ff @(posedge clk) begin
        stage_q <= stage_i;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            strobe_q <= 1'b0;
            merge_q <= 1'b0;
        end else begin
            // strobes during a merge are dropped
            strobe_q <= stage_valid_i && !merge_q;
            if (merge_q) begin
                // a quiet update cycle means the grid has settled
                if (changed_i == '0) begin
                    merge_q <= 1'b0;
                end
            end else if (stage_valid_i && stage_i == STAGE_MERGE) begin
                merge_q <= 1'b1;
            end
        end
    end

    assign load_o = strobe_q && (stage_q == STAGE_LOAD);
    assign grow_o = strobe_q && (stage_q == STAGE_GROW);
    assign merge_active_o = merge_q;
    assign busy_o = merge_q;

endmodule

//--- hdl/processing_unit.sv
module processing_unit #(
    parameter int PU_INDEX = 0,
    parameter int NEIGHBOR_COUNT = 6
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  load_i,
    input  logic                  merge_active_i,
    input  logic                  syndrome_i,
    link_if.side_a                a_links [decoder_pkg::LINK_SLOTS],
    link_if.side_b                b_links [decoder_pkg::LINK_SLOTS],
    output decoder_pkg::address_t root_o,
    output logic                  occupied_o,
    output logic                  changed_o
);
    import decoder_pkg::*;

    address_t                            root_q;
    logic                                occupied_q;
    address_t [NEIGHBOR_COUNT-1:0]       nbr_root;
    logic [NEIGHBOR_COUNT-1:0]           nbr_occupied;
    logic [NEIGHBOR_COUNT-1:0]           nbr_grown;
    address_t                            next_root;
    logic                                next_occupied;

    // gather the far ends of every existing edge into a compact list
    for (genvar s = 0; s < 2 * DIR_COUNT; s++) begin : g_side
        if (has_neighbor(PU_INDEX, s)) begin : g_edge
            localparam int POS = neighbor_pos(PU_INDEX, s);
            localparam int SLOT = link_slot(PU_INDEX, s);
            if (s < DIR_COUNT) begin : g_lower
                // lower neighbor owns the slot, this unit is end B
                assign b_links[SLOT].b_root = root_q;
                assign b_links[SLOT].b_occupied = occupied_q;
                assign nbr_root[POS] = b_links[SLOT].a_root;
                assign nbr_occupied[POS] = b_links[SLOT].a_occupied;
                assign nbr_grown[POS] = b_links[SLOT].fully_grown;
            end else begin : g_upper
                assign a_links[SLOT].a_root = root_q;
                assign a_links[SLOT].a_occupied = occupied_q;
                assign nbr_root[POS] = a_links[SLOT].b_root;
                assign nbr_occupied[POS] = a_links[SLOT].b_occupied;
                assign nbr_grown[POS] = a_links[SLOT].fully_grown;
            end
        end
    end

    // smallest root and occupancy across fully grown edges
    always_comb begin
        next_root = root_q;
        next_occupied = occupied_q;
        for (int n = 0; n < NEIGHBOR_COUNT; n++) begin
            if (nbr_grown[n]) begin
                if (nbr_root[n] < next_root) begin
                    next_root = nbr_root[n];
                end
                next_occupied = next_occupied | nbr_occupied[n];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            root_q <= '0;
            occupied_q <= 1'b0;
        end else if (load_i) begin
            root_q <= address_t'(PU_INDEX);
            occupied_q <= syndrome_i;
        end else if (merge_active_i) begin
            root_q <= next_root;
            occupied_q <= next_occupied;
        end
    end

    assign changed_o = merge_active_i &&
                       ((next_root != root_q) || (next_occupied != occupied_q));
    assign root_o = root_q;
    assign occupied_o = occupied_q;

endmodule

//--- hdl/neighbor_link.sv
module neighbor_link #(
    parameter int LENGTH = 2
) (
    input  logic clk,
    input  logic reset,
    input  logic load_i,
    input  logic grow_i,
    link_if.link link_port
);
    import decoder_pkg::*;

    localparam logic [GROWTH_WIDTH-1:0] FULL = GROWTH_WIDTH'(LENGTH);

    logic [GROWTH_WIDTH-1:0] growth_q;
    logic                    touched;

    // only edges next to an occupied cluster grow
    assign touched = link_port.a_occupied || link_port.b_occupied;

    always_ff @(posedge clk) begin
        if (reset) begin
            growth_q <= '0;
        end else if (load_i) begin
            growth_q <= '0;
        end else if (grow_i && touched && growth_q < FULL) begin
            growth_q <= growth_q + 1'b1;
        end
    end

    assign link_port.fully_grown = (growth_q == FULL);

endmodule

//--- hdl/pu_grid.sv
module pu_grid (
    input  logic                                             clk,
    input  logic                                             reset,
    input  logic                                             load_i,
    input  logic                                             grow_i,
    input  logic                                             merge_active_i,
    input  logic [decoder_pkg::PU_COUNT-1:0]                 syndrome_i,
    output decoder_pkg::address_t [decoder_pkg::PU_COUNT-1:0] roots_o,
    output logic [decoder_pkg::PU_COUNT-1:0]                 occupied_o,
    output logic [decoder_pkg::PU_COUNT-1:0]                 changed_o
);
    import decoder_pkg::*;

    // three slots per unit; slots pointing off the grid stay empty
    link_if links [LINK_SLOTS] ();

    for (genvar k = 0; k < MEASUREMENT_ROUNDS; k++) begin : g_k
        for (genvar i = 0; i < CODE_DISTANCE_X; i++) begin : g_i
            for (genvar j = 0; j < CODE_DISTANCE_Z; j++) begin : g_j
                localparam int IDX = pu_index(i, j, k);

                processing_unit #(
                    .PU_INDEX(IDX),
                    .NEIGHBOR_COUNT(neighbor_count(IDX))
                ) u_pu (
                    .clk(clk),
                    .reset(reset),
                    .load_i(load_i),
                    .merge_active_i(merge_active_i),
                    .syndrome_i(syndrome_i[IDX]),
                    .a_links(links),
                    .b_links(links),
                    .root_o(roots_o[IDX]),
                    .occupied_o(occupied_o[IDX]),
                    .changed_o(changed_o[IDX])
                );

                // edge to the next row
                if (i < CODE_DISTANCE_X - 1) begin : g_x
                    neighbor_link #(
                        .LENGTH(NEIGHBOR_COST_X)
                    ) u_link (
                        .clk(clk),
                        .reset(reset),
                        .load_i(load_i),
                        .grow_i(grow_i),
                        .link_port(links[IDX * DIR_COUNT + DIR_X])
                    );
                end

                // edge to the next column
                if (j < CODE_DISTANCE_Z - 1) begin : g_z
                    neighbor_link #(
                        .LENGTH(NEIGHBOR_COST_Z)
                    ) u_link (
                        .clk(clk),
                        .reset(reset),
                        .load_i(load_i),
                        .grow_i(grow_i),
                        .link_port(links[IDX * DIR_COUNT + DIR_Z])
                    );
                end

                // time-like edge to the next measurement round
                if (k < MEASUREMENT_ROUNDS - 1) begin : g_ud
                    neighbor_link #(
                        .LENGTH(NEIGHBOR_COST_UD)
                    ) u_link (
                        .clk(clk),
                        .reset(reset),
                        .load_i(load_i),
                        .grow_i(grow_i),
                        .link_port(links[IDX * DIR_COUNT + DIR_UD])
                    );
                end
            end
        end
    end

endmodule

//--- hdl/decoder_top.sv
module decoder_top (
    input  logic                                             clk,
    input  logic                                             reset,
    input  decoder_pkg::stage_t                              stage_i,
    input  logic                                             stage_valid_i,
    input  logic [decoder_pkg::PU_COUNT-1:0]                 syndrome_i,
    output decoder_pkg::address_t [decoder_pkg::PU_COUNT-1:0] roots_o,
    output logic [decoder_pkg::PU_COUNT-1:0]                 occupied_o,
    output logic                                             busy_o
);
    import decoder_pkg::*;

    logic                load;
    logic                grow;
    logic                merge_active;
    logic [PU_COUNT-1:0] changed;

    stage_control u_stage_control (
        .clk(clk),
        .reset(reset),
        .stage_i(stage_i),
        .stage_valid_i(stage_valid_i),
        .changed_i(changed),
        .load_o(load),
        .grow_o(grow),
        .merge_active_o(merge_active),
        .busy_o(busy_o)
    );

    pu_grid u_pu_grid (
        .clk(clk),
        .reset(reset),
        .load_i(load),
        .grow_i(grow),
        .merge_active_i(merge_active),
        .syndrome_i(syndrome_i),
        .roots_o(roots_o),
        .occupied_o(occupied_o),
        .changed_o(changed)
    );

endmodule

//--- tests/decoder_checker.sv
module decoder_checker (
    input  logic                                              clk,
    input  logic                                              reset,
    input  decoder_pkg::stage_t                               stage_i,
    input  logic                                              stage_valid_i,
    input  logic [decoder_pkg::PU_COUNT-1:0]                  syndrome_i,
    input  decoder_pkg::address_t [decoder_pkg::PU_COUNT-1:0] roots_i,
    input  logic [decoder_pkg::PU_COUNT-1:0]                  occupied_i,
    input  logic                                              busy_i,
    output int                                                error_count_o,
    output int                                                check_count_o
);
    timeunit 1ns;
    timeprecision 1ps;
    import decoder_pkg::*;

    localparam int SETTLE_CYCLES = 2;

    // links of each unit toward higher row, higher column and next layer
    int                  link_far [PU_COUNT][3];
    int                  link_cost [PU_COUNT][3];
    int                  link_growth [PU_COUNT][3];
    int                  exp_root [PU_COUNT];
    logic                exp_occ [PU_COUNT];
    logic [PU_COUNT-1:0] syndrome_q;
    int                  errors;
    int                  checks;
    int                  settle_count;
    int                  merge_cycles;
    logic                merge_pending;
    logic                reset_seen;

    assign error_count_o = errors;
    assign check_count_o = checks;

    initial begin
        int row;
        int col;
        int layer;
        errors = 0;
        checks = 0;
        settle_count = 0;
        merge_cycles = 0;
        merge_pending = 1'b0;
        reset_seen = 1'b0;
        for (int u = 0; u < PU_COUNT; u++) begin
            row = (u / CODE_DISTANCE_Z) % CODE_DISTANCE_X;
            col = u % CODE_DISTANCE_Z;
            layer = u / (CODE_DISTANCE_Z * CODE_DISTANCE_X);
            link_far[u][0] = (row < CODE_DISTANCE_X - 1) ? u + CODE_DISTANCE_Z : -1;
            link_far[u][1] = (col < CODE_DISTANCE_Z - 1) ? u + 1 : -1;
            link_far[u][2] = (layer < MEASUREMENT_ROUNDS - 1) ?
                             u + CODE_DISTANCE_Z * CODE_DISTANCE_X : -1;
            link_cost[u][0] = NEIGHBOR_COST_X;
            link_cost[u][1] = NEIGHBOR_COST_Z;
            link_cost[u][2] = NEIGHBOR_COST_UD;
        end
    end

    // smallest index and syndrome OR of each component over fully grown links
    function automatic void merge_reference();
        logic changed;
        int   far;
        for (int u = 0; u < PU_COUNT; u++) begin
            exp_root[u] = u;
            exp_occ[u] = syndrome_q[u];
        end
        changed = 1'b1;
        while (changed) begin
            changed = 1'b0;
            for (int u = 0; u < PU_COUNT; u++) begin
                for (int d = 0; d < 3; d++) begin
                    far = link_far[u][d];
                    if (far >= 0 && link_growth[u][d] == link_cost[u][d]) begin
                        if (exp_root[far] < exp_root[u]) begin
                            exp_root[u] = exp_root[far];
                            changed = 1'b1;
                        end else if (exp_root[u] < exp_root[far]) begin
                            exp_root[far] = exp_root[u];
                            changed = 1'b1;
                        end
                        if (exp_occ[u] != exp_occ[far]) begin
                            exp_occ[u] = 1'b1;
                            exp_occ[far] = 1'b1;
                            changed = 1'b1;
                        end
                    end
                end
            end
        end
    endfunction

    task automatic compare_units(input string what, input logic busy_expected);
        checks++;
        if (busy_i != busy_expected) begin
            errors++;
            $display("Fail %0t: %s busy expected %0b got %0b", $time, what, busy_expected, busy_i);
        end
        for (int u = 0; u < PU_COUNT; u++) begin
            if (int'(roots_i[u]) != exp_root[u]) begin
                errors++;
                $display("Fail %0t: %s unit %0d root expected %0d got %0d",
                         $time, what, u, exp_root[u], roots_i[u]);
            end
            if (occupied_i[u] != exp_occ[u]) begin
                errors++;
                $display("Fail %0t: %s unit %0d occupied expected %0b got %0b",
                         $time, what, u, exp_occ[u], occupied_i[u]);
            end
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            for (int u = 0; u < PU_COUNT; u++) begin
                exp_root[u] = 0;
                exp_occ[u] = 1'b0;
                for (int d = 0; d < 3; d++) begin
                    link_growth[u][d] = 0;
                end
            end
            syndrome_q = '0;
            settle_count = 0;
            merge_pending = 1'b0;
            reset_seen = 1'b1;
        end else begin
            if (reset_seen) begin
                compare_units("after reset", 1'b0);
                reset_seen = 1'b0;
            end
            if (settle_count > 0) begin
                settle_count--;
                if (settle_count == 0) begin
                    compare_units("after load or grow", 1'b0);
                end
            end
            if (merge_pending) begin
                merge_cycles++;
                if (merge_cycles == 1 && !busy_i) begin
                    errors++;
                    $display("Fail %0t: busy did not rise after a merge strobe", $time);
                    merge_pending = 1'b0;
                end else if (merge_cycles > 1 && !busy_i) begin
                    compare_units("after merge", 1'b0);
                    merge_pending = 1'b0;
                end
            end
            // strobes arriving during a merge are dropped by the DUT
            if (stage_valid_i && !busy_i) begin
                case (stage_i)
                    STAGE_LOAD: begin
                        syndrome_q = syndrome_i;
                        for (int u = 0; u < PU_COUNT; u++) begin
                            exp_root[u] = u;
                            exp_occ[u] = syndrome_i[u];
                            for (int d = 0; d < 3; d++) begin
                                link_growth[u][d] = 0;
                            end
                        end
                        settle_count = SETTLE_CYCLES;
                    end
                    STAGE_GROW: begin
                        for (int u = 0; u < PU_COUNT; u++) begin
                            for (int d = 0; d < 3; d++) begin
                                if (link_far[u][d] >= 0 && link_growth[u][d] < link_cost[u][d]
                                    && (exp_occ[u] || exp_occ[link_far[u][d]])) begin
                                    link_growth[u][d]++;
                                end
                            end
                        end
                        settle_count = SETTLE_CYCLES;
                    end
                    STAGE_MERGE: begin
                        merge_reference();
                        merge_cycles = 0;
                        merge_pending = 1'b1;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

//--- tests/tb_decoder.sv
module tb_decoder;
    timeunit 1ns;
    timeprecision 1ps;
    import decoder_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int RESET_CYCLES = 16;
    localparam int SINGLE_ROUNDS = 3;
    localparam int PAIR_ROUNDS = 3;
    localparam int RANDOM_PATTERNS = 10;
    localparam int RANDOM_ROUNDS = 4;
    localparam int EMPTY_ROUNDS = 3;
    // one load plus a grow and a merge per round
    localparam int STROBE_TOTAL = (1 + 2 * SINGLE_ROUNDS) + (1 + 2 * PAIR_ROUNDS) +
                                  RANDOM_PATTERNS * (1 + 2 * RANDOM_ROUNDS) +
                                  (1 + 2 * EMPTY_ROUNDS);
    localparam int TIMEOUT_CYCLES = 200 * STROBE_TOTAL + RESET_CYCLES + 20;

    logic                    clk;
    logic                    reset;
    stage_t                  stage;
    logic                    stage_valid;
    logic [PU_COUNT-1:0]     syndrome;
    address_t [PU_COUNT-1:0] roots;
    logic [PU_COUNT-1:0]     occupied;
    logic                    busy;
    int                      error_count;
    int                      check_count;

    decoder_top dut0 (
        .clk(clk),
        .reset(reset),
        .stage_i(stage),
        .stage_valid_i(stage_valid),
        .syndrome_i(syndrome),
        .roots_o(roots),
        .occupied_o(occupied),
        .busy_o(busy)
    );

    decoder_checker checker0 (
        .clk(clk),
        .reset(reset),
        .stage_i(stage),
        .stage_valid_i(stage_valid),
        .syndrome_i(syndrome),
        .roots_i(roots),
        .occupied_i(occupied),
        .busy_i(busy),
        .error_count_o(error_count),
        .check_count_o(check_count)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic send_stage(input stage_t code);
        @(posedge clk);
        stage <= code;
        stage_valid <= 1'b1;
        @(posedge clk);
        stage <= STAGE_IDLE;
        stage_valid <= 1'b0;
        if (code == STAGE_MERGE) begin
            // busy rises one cycle after the strobe and falls once the grid is stable
            @(posedge clk);
            while (busy) begin
                @(posedge clk);
            end
        end else begin
            repeat (3) @(posedge clk);
        end
    endtask

    task automatic run_decode(input logic [PU_COUNT-1:0] pattern, input int rounds);
        @(posedge clk);
        syndrome <= pattern;
        send_stage(STAGE_LOAD);
        for (int r = 0; r < rounds; r++) begin
            send_stage(STAGE_GROW);
            send_stage(STAGE_MERGE);
        end
    endtask

    initial begin
        logic [PU_COUNT-1:0] pattern;
        reset = 1'b1;
        stage = STAGE_IDLE;
        stage_valid = 1'b0;
        syndrome = '0;
        void'($urandom(8820));
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        repeat (2) @(posedge clk);

        // lone defect in the middle of the cube
        pattern = '0;
        pattern[13] = 1'b1;
        run_decode(pattern, SINGLE_ROUNDS);

        // two defects two steps apart in the middle layer
        pattern = '0;
        pattern[10] = 1'b1;
        pattern[12] = 1'b1;
        run_decode(pattern, PAIR_ROUNDS);

        for (int p = 0; p < RANDOM_PATTERNS; p++) begin
            pattern = PU_COUNT'($urandom() & $urandom());
            run_decode(pattern, RANDOM_ROUNDS);
        end

        // no defects, so no link may grow
        run_decode('0, EMPTY_ROUNDS);

        repeat (4) @(posedge clk);
        $display("errors: %0d, checks: %0d", error_count, check_count);
        if (error_count == 0 && check_count > 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("the run timed out after %0d cycles", TIMEOUT_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

//--- vlog.f
hdl/decoder_pkg.sv
hdl/link_if.sv
hdl/stage_control.sv
hdl/processing_unit.sv
hdl/neighbor_link.sv
hdl/pu_grid.sv
hdl/decoder_top.sv
tests/decoder_checker.sv
tests/tb_decoder.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -j 0 \
    --top-module tb_decoder -f vlog.f -o tb_decoder

./obj_dir/tb_decoder > sim.log 2>&1
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "PASS: all tests" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
